//--- include/volley_defines.svh
`ifndef VOLLEY_DEFINES_SVH
`define VOLLEY_DEFINES_SVH

// fixed point
`define POS_W 12
`define FRAC_W 7
`define VEL_W 10 // 7 of them fraction

// screen geometry in pixels, y grows downward
`define BALL_SIZE 64
`define BALL_CENTER 32
`define GND_LVL 750
`define WALL_LEFT 5
`define WALL_RIGHT 1018
`define NET_X_LO 508
`define NET_X_HI 516
`define NET_TOP 480

// player sprite
`define PL_W 76
`define PL_H 90
`define PL_CENTER_X 38
`define PL_CENTER_Y 45

`define SERVE_X_PL1 250
`define SERVE_X_PL2 774
`define SERVE_Y 555

`define VEL_Y_MIN (-384) // terminal fall, 3 px per tick

`define WAIT_TICKS 250
`define GHOST_TICKS 25
`define MAX_TOUCHES 3

`endif

//--- verilog/volley_pkg.sv
package volley_pkg;

	// rally phases
	typedef enum logic [1:0] {
		HANG,
		BOUNCE,
		FLIGHT,
		WAIT
	} ball_state_t;

	// listed in falling priority after NONE
	typedef enum logic [2:0] {
		NONE,
		PL1,
		PL2,
		WALL,
		NET,
		GND
	} collision_t;

	typedef enum logic {
		PLAYER1,
		PLAYER2
	} player_t;

endpackage

//--- verilog/ball_state_fsm.sv
`timescale 1ns/10ps

module ball_state_fsm (
	input wire clk100Hz,
	input wire rst_d,
	input wire pl1_col,
	input wire pl2_col,
	input wire wall_col,
	input wire net_col,
	input wire gnd_col,
	input wire ghost_done,
	input wire wait_done,
	input wire ovr_touch,
	output volley_pkg::ball_state_t state
);
	import volley_pkg::*;

	ball_state_t state_nxt;
	logic player_hit;
	logic any_hit;

	assign player_hit = pl1_col || pl2_col;
	assign any_hit = player_hit || wall_col || net_col;

	always_ff @(posedge clk100Hz) begin
		if (rst_d) begin
			state <= HANG;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			HANG: begin
				if (player_hit) begin
					state_nxt = BOUNCE; // serve touch
				end
			end
			BOUNCE: begin
				if (ovr_touch) begin
					state_nxt = WAIT;
				end else begin
					state_nxt = FLIGHT;
				end
			end
			FLIGHT: begin
				// bounces win over the ground, but only after the ghost period
				if (any_hit && ghost_done) begin
					state_nxt = BOUNCE;
				end else if (gnd_col) begin
					state_nxt = WAIT;
				end
			end
			WAIT: begin
				if (wait_done) begin
					state_nxt = HANG;
				end
			end
			default: begin
				state_nxt = HANG;
			end
		endcase
	end

endmodule

//--- verilog/ball_timers.sv
`timescale 1ns/10ps
`include "volley_defines.svh"

module ball_timers (
	input wire clk100Hz,
	input wire rst_d,
	input volley_pkg::ball_state_t state,
	output logic wait_done,
	output logic ghost_done
);
	import volley_pkg::*;

	logic [$clog2(`WAIT_TICKS)-1:0] wait_cnt;
	logic [$clog2(`GHOST_TICKS+1)-1:0] ghost_cnt;

	// last tick of the wait period
	assign wait_done = (state == WAIT) && (wait_cnt == `WAIT_TICKS - 1);
	assign ghost_done = (ghost_cnt == `GHOST_TICKS);

	always_ff @(posedge clk100Hz) begin
		if (rst_d) begin
			wait_cnt <= '0;
		end else if (state == WAIT) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else begin
			wait_cnt <= '0;
		end
	end

	// saturates so one overlap never bounces twice
	always_ff @(posedge clk100Hz) begin
		if (rst_d) begin
			ghost_cnt <= '0;
		end else if (state == FLIGHT) begin
			if (!ghost_done) begin
				ghost_cnt <= ghost_cnt + 1'b1;
			end
		end else begin
			ghost_cnt <= '0; // restarts from every bounce
		end
	end

endmodule

//--- verilog/collision_detect.sv
`timescale 1ns/10ps
`include "volley_defines.svh"

module collision_detect (
	input wire [`POS_W+`FRAC_W-1:0] next_posx,
	input wire [`POS_W+`FRAC_W-1:0] next_posy,
	input wire [`POS_W-1:0] ball_posx,
	input wire [`POS_W-1:0] ball_posy,
	input wire [`POS_W-1:0] pl1_posx,
	input wire [`POS_W-1:0] pl1_posy,
	input wire [`POS_W-1:0] pl2_posx,
	input wire [`POS_W-1:0] pl2_posy,
	output logic pl1_col,
	output logic pl2_col,
	output logic wall_col,
	output logic net_col,
	output logic gnd_col,
	output volley_pkg::collision_t col_kind
);
	import volley_pkg::*;

	logic [`POS_W-1:0] nx;
	logic [`POS_W-1:0] ny;

	// ball box against a player box
	function automatic logic box_hit(
		input logic [`POS_W-1:0] bx,
		input logic [`POS_W-1:0] by,
		input logic [`POS_W-1:0] px,
		input logic [`POS_W-1:0] py
	);
		box_hit = (bx < px + `PL_W) && (px < bx + `BALL_SIZE)
			&& (by < py + `PL_H) && (py < by + `BALL_SIZE);
	endfunction

	assign nx = next_posx[`POS_W+`FRAC_W-1:`FRAC_W];
	assign ny = next_posy[`POS_W+`FRAC_W-1:`FRAC_W];

	assign pl1_col = box_hit(ball_posx, ball_posy, pl1_posx, pl1_posy);
	assign pl2_col = box_hit(ball_posx, ball_posy, pl2_posx, pl2_posy);

	// a wrap past zero lands in the right hand test
	assign wall_col = (nx <= `WALL_LEFT) || (nx + `BALL_SIZE >= `WALL_RIGHT);
	assign gnd_col = (ny + `BALL_SIZE >= `GND_LVL);
	assign net_col = (nx < `NET_X_HI) && (nx + `BALL_SIZE > `NET_X_LO)
		&& (ny + `BALL_SIZE > `NET_TOP);

	always_comb begin
		if (pl1_col) begin
			col_kind = PL1;
		end else if (pl2_col) begin
			col_kind = PL2;
		end else if (wall_col) begin
			col_kind = WALL;
		end else if (net_col) begin
			col_kind = NET;
		end else if (gnd_col) begin
			col_kind = GND;
		end else begin
			col_kind = NONE;
		end
	end

endmodule

//--- verilog/ball_kinematics.sv
`timescale 1ns/10ps
`include "volley_defines.svh"

module ball_kinematics (
	input wire clk100Hz,
	input wire rst_d,
	input volley_pkg::ball_state_t state,
	input volley_pkg::collision_t col_kind,
	input volley_pkg::player_t hit_player,
	input volley_pkg::player_t serve_side,
	input wire [`POS_W-1:0] pl1_posx,
	input wire [`POS_W-1:0] pl1_posy,
	input wire [`POS_W-1:0] pl2_posx,
	input wire [`POS_W-1:0] pl2_posy,
	output logic [`POS_W+`FRAC_W-1:0] next_posx,
	output logic [`POS_W+`FRAC_W-1:0] next_posy,
	output logic [`POS_W-1:0] ball_posx,
	output logic [`POS_W-1:0] ball_posy
);
	import volley_pkg::*;

	logic [`POS_W+`FRAC_W-1:0] pos_x;
	logic [`POS_W+`FRAC_W-1:0] pos_y;
	logic [`POS_W+`FRAC_W-1:0] vel_x_ext;
	logic [`POS_W+`FRAC_W-1:0] vel_y_ext;
	logic [`POS_W-1:0] serve_x;
	logic signed [`VEL_W-1:0] vel_x, vel_y;
	logic signed [`VEL_W-1:0] vel_x_nxt, vel_y_nxt;
	logic signed [`VEL_W-1:0] hit_vx1, hit_vy1;
	logic signed [`VEL_W-1:0] hit_vx2, hit_vy2;
	collision_t bounce_kind;

	// signed distance a - b + bias in pixels
	function automatic logic signed [`POS_W:0] centre_offset(
		input logic [`POS_W-1:0] a,
		input logic [`POS_W-1:0] b,
		input logic signed [`POS_W:0] bias
	);
		centre_offset = $signed({1'b0, a}) - $signed({1'b0, b}) + bias;
	endfunction

	// times four; an overlap keeps the offset well inside 8 bits
	function automatic logic signed [`VEL_W-1:0] to_vel(input logic signed [`POS_W:0] off);
		to_vel = {off[`VEL_W-3:0], 2'b00};
	endfunction

	assign ball_posx = pos_x[`POS_W+`FRAC_W-1:`FRAC_W];
	assign ball_posy = pos_y[`POS_W+`FRAC_W-1:`FRAC_W];

	assign vel_x_ext = {{(`POS_W+`FRAC_W-`VEL_W){vel_x[`VEL_W-1]}}, vel_x};
	assign vel_y_ext = {{(`POS_W+`FRAC_W-`VEL_W){vel_y[`VEL_W-1]}}, vel_y};
	assign serve_x = (serve_side == PLAYER2) ? `POS_W'(`SERVE_X_PL2) : `POS_W'(`SERVE_X_PL1);

	// hit velocities taken while the overlap is seen and used in the following bounce
	always_ff @(posedge clk100Hz) begin
		if (state != BOUNCE) begin
			hit_vx1 <= to_vel(centre_offset(ball_posx, pl1_posx,
				(`POS_W+1)'(`BALL_CENTER - `PL_CENTER_X)));
			hit_vy1 <= to_vel(centre_offset(pl1_posy, ball_posy,
				(`POS_W+1)'(`PL_CENTER_Y - `BALL_CENTER)));
			hit_vx2 <= to_vel(centre_offset(ball_posx, pl2_posx,
				(`POS_W+1)'(`BALL_CENTER - `PL_CENTER_X)));
			hit_vy2 <= to_vel(centre_offset(pl2_posy, ball_posy,
				(`POS_W+1)'(`PL_CENTER_Y - `BALL_CENTER)));
		end
	end

	always_ff @(posedge clk100Hz) begin
		if (rst_d) begin
			bounce_kind <= NONE;
		end else if (state != BOUNCE) begin
			bounce_kind <= col_kind;
		end
	end

	always_comb begin
		case (state)
			HANG: begin
				next_posx = {serve_x, {`FRAC_W{1'b0}}};
				next_posy = {`POS_W'(`SERVE_Y), {`FRAC_W{1'b0}}};
			end
			FLIGHT: begin
				next_posx = pos_x + vel_x_ext;
				next_posy = pos_y - vel_y_ext; // positive vel_y is upward
			end
			default: begin
				next_posx = pos_x;
				next_posy = pos_y;
			end
		endcase
	end

	always_comb begin
		vel_x_nxt = '0;
		vel_y_nxt = '0;
		case (state)
			BOUNCE: begin
				vel_x_nxt = vel_x;
				vel_y_nxt = vel_y;
				case (bounce_kind)
					PL1, PL2: begin
						vel_x_nxt = (hit_player == PLAYER2) ? hit_vx2 : hit_vx1;
						vel_y_nxt = (hit_player == PLAYER2) ? hit_vy2 : hit_vy1;
					end
					WALL: begin
						vel_x_nxt = -vel_x;
					end
					NET: begin
						vel_x_nxt = -vel_x;
						vel_y_nxt = vel_y >>> 1; // net eats half the lift
					end
					default: begin
					end
				endcase
			end
			FLIGHT: begin
				vel_x_nxt = vel_x;
				vel_y_nxt = (vel_y > `VEL_Y_MIN) ? vel_y - `VEL_W'sd1 : vel_y; // gravity
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk100Hz) begin
		if (rst_d) begin
			pos_x <= '0;
			pos_y <= '0;
			vel_x <= '0;
			vel_y <= '0;
		end else begin
			pos_x <= next_posx;
			pos_y <= next_posy;
			vel_x <= vel_x_nxt;
			vel_y <= vel_y_nxt;
		end
	end

endmodule

//--- verilog/touch_referee.sv
`timescale 1ns/10ps
`include "volley_defines.svh"

module touch_referee (
	input wire clk100Hz,
	input wire rst_d,
	input volley_pkg::ball_state_t state,
	input volley_pkg::collision_t col_kind,
	output logic ovr_touch,
	output volley_pkg::player_t serve_side,
	output volley_pkg::player_t hit_player
);
	import volley_pkg::*;

	collision_t touch_kind; // kind that led into the bounce
	player_t last_touch;
	logic [2:0] touch_cnt;
	logic player_hit;
	logic same_player;

	always_ff @(posedge clk100Hz) begin
		if (rst_d) begin
			touch_kind <= NONE;
		end else if (state != BOUNCE) begin
			touch_kind <= col_kind;
		end
	end

	assign player_hit = (state == BOUNCE) && ((touch_kind == PL1) || (touch_kind == PL2));
	assign hit_player = (touch_kind == PL2) ? PLAYER2 : PLAYER1;
	assign same_player = (hit_player == last_touch);
	// fourth touch in a row by one side
	assign ovr_touch = player_hit && same_player && (touch_cnt == `MAX_TOUCHES);

	always_ff @(posedge clk100Hz) begin
		if (rst_d) begin
			last_touch <= PLAYER1;
			touch_cnt <= '0;
			serve_side <= PLAYER1;
		end else begin
			if (state == HANG) begin
				touch_cnt <= '0;
			end else if (player_hit && !ovr_touch) begin
				last_touch <= hit_player;
				touch_cnt <= same_player ? touch_cnt + 1'b1 : 3'd1;
			end

			if (ovr_touch) begin
				serve_side <= (hit_player == PLAYER1) ? PLAYER2 : PLAYER1;
			end else if (state == FLIGHT) begin
				serve_side <= last_touch; // holds if the flight ends on the ground
			end
		end
	end

endmodule

//--- verilog/volley_ball_core.sv
`timescale 1ns/10ps
`include "volley_defines.svh"

module volley_ball_core (
	input wire clk100Hz,
	input wire rst_d,
	input wire [`POS_W-1:0] pl1_posx,
	input wire [`POS_W-1:0] pl1_posy,
	input wire [`POS_W-1:0] pl2_posx,
	input wire [`POS_W-1:0] pl2_posy,
	output logic [`POS_W-1:0] ball_posx,
	output logic [`POS_W-1:0] ball_posy,
	output logic gnd_col,
	output logic ovr_touch
);
	import volley_pkg::*;

	ball_state_t state;
	collision_t col_kind;
	player_t serve_side;
	player_t hit_player;
	logic pl1_col, pl2_col, wall_col, net_col;
	logic wait_done, ghost_done;
	logic [`POS_W+`FRAC_W-1:0] next_posx;
	logic [`POS_W+`FRAC_W-1:0] next_posy;

	ball_state_fsm u_fsm (
		.clk100Hz(clk100Hz),
		.rst_d(rst_d),
		.pl1_col(pl1_col),
		.pl2_col(pl2_col),
		.wall_col(wall_col),
		.net_col(net_col),
		.gnd_col(gnd_col),
		.ghost_done(ghost_done),
		.wait_done(wait_done),
		.ovr_touch(ovr_touch),
		.state(state)
	);

	ball_timers u_timers (
		.clk100Hz(clk100Hz),
		.rst_d(rst_d),
		.state(state),
		.wait_done(wait_done),
		.ghost_done(ghost_done)
	);

	// walls, net and ground look one tick ahead, players use the current ball
	collision_detect u_col (
		.next_posx(next_posx),
		.next_posy(next_posy),
		.ball_posx(ball_posx),
		.ball_posy(ball_posy),
		.pl1_posx(pl1_posx),
		.pl1_posy(pl1_posy),
		.pl2_posx(pl2_posx),
		.pl2_posy(pl2_posy),
		.pl1_col(pl1_col),
		.pl2_col(pl2_col),
		.wall_col(wall_col),
		.net_col(net_col),
		.gnd_col(gnd_col),
		.col_kind(col_kind)
	);

	ball_kinematics u_kin (
		.clk100Hz(clk100Hz),
		.rst_d(rst_d),
		.state(state),
		.col_kind(col_kind),
		.hit_player(hit_player),
		.serve_side(serve_side),
		.pl1_posx(pl1_posx),
		.pl1_posy(pl1_posy),
		.pl2_posx(pl2_posx),
		.pl2_posy(pl2_posy),
		.next_posx(next_posx),
		.next_posy(next_posy),
		.ball_posx(ball_posx),
		.ball_posy(ball_posy)
	);

	touch_referee u_ref (
		.clk100Hz(clk100Hz),
		.rst_d(rst_d),
		.state(state),
		.col_kind(col_kind),
		.ovr_touch(ovr_touch),
		.serve_side(serve_side),
		.hit_player(hit_player)
	);

endmodule

//--- testbench/volley_ball_core_tb.sv
`timescale 1ns/10ps
`include "volley_defines.svh"

module volley_ball_core_tb;

	localparam int max_step = (1 << (`VEL_W - 1)) >> `FRAC_W; // px per tick of the fastest ball
	localparam int park_pos = 2000; // off screen so it never touches the ball

	logic clk100Hz;
	logic rst_d;
	logic [`POS_W-1:0] pl1_posx;
	logic [`POS_W-1:0] pl1_posy;
	logic [`POS_W-1:0] pl2_posx;
	logic [`POS_W-1:0] pl2_posy;
	wire [`POS_W-1:0] ball_posx;
	wire [`POS_W-1:0] ball_posy;
	wire gnd_col;
	wire ovr_touch;

	int errors;
	int tests;
	int tests_ok;
	int unsigned lcg_state;

	volley_ball_core uut (
		.clk100Hz(clk100Hz),
		.rst_d(rst_d),
		.pl1_posx(pl1_posx),
		.pl1_posy(pl1_posy),
		.pl2_posx(pl2_posx),
		.pl2_posy(pl2_posy),
		.ball_posx(ball_posx),
		.ball_posy(ball_posy),
		.gnd_col(gnd_col),
		.ovr_touch(ovr_touch)
	);

	always #50 clk100Hz = ~clk100Hz;

	function automatic int lcg_range(input int lo, input int hi);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lo + int'((lcg_state >> 16) % (hi - lo + 1));
	endfunction

	// how deep the ball box sits in the net column, 0 when clear
	function automatic int net_depth(input int x, input int y);
		int d_left;
		int d_right;
		int d_top;
		int d;
		d_left = x + `BALL_SIZE - `NET_X_LO;
		d_right = `NET_X_HI - x;
		d_top = y + `BALL_SIZE - `NET_TOP;
		d = (d_left < d_right) ? d_left : d_right;
		d = (d_top < d) ? d_top : d;
		return (d > 0) ? d : 0;
	endfunction

	task automatic drive_player(input int who, input int x, input int y);
		@(posedge clk100Hz);
		if (who == 1) begin
			pl1_posx <= `POS_W'(x);
			pl1_posy <= `POS_W'(y);
		end else begin
			pl2_posx <= `POS_W'(x);
			pl2_posy <= `POS_W'(y);
		end
	endtask

	task automatic park_players();
		@(posedge clk100Hz);
		pl1_posx <= `POS_W'(park_pos);
		pl1_posy <= `POS_W'(park_pos);
		pl2_posx <= `POS_W'(park_pos);
		pl2_posy <= `POS_W'(park_pos);
	endtask

	task automatic report_test(input string name, input int start);
		tests++;
		if (errors == start) begin
			tests_ok++;
			$display("test %-12s ok", name);
		end else begin
			$display("test %-12s failed, %0d errors", name, errors - start);
		end
	endtask

	task automatic check_position(input int x, input int y, input string what);
		assert ((ball_posx == x) && (ball_posy == y)) else begin
			$display("ERROR at %0t ns: %s, ball at (%0d,%0d), expected (%0d,%0d)",
				$time, what, ball_posx, ball_posy, x, y);
			errors++;
		end
	endtask

	task automatic check_flight();
		int x;
		int y;
		x = ball_posx;
		y = ball_posy;
		assert ((x + max_step >= `WALL_LEFT) && (x + `BALL_SIZE <= `WALL_RIGHT + max_step)) else begin
			$display("ERROR at %0t ns: ball x=%0d is outside the walls", $time, x);
			errors++;
		end
		assert (net_depth(x, y) <= max_step) else begin
			$display("ERROR at %0t ns: ball (%0d,%0d) is inside the net", $time, x, y);
			errors++;
		end
	endtask

	// ox is how far the ball centre sits right of the player centre
	// oy is how far the player centre sits below the ball centre
	task automatic touch_ball(input int who, input int ox, input int oy);
		int px;
		int py;
		px = int'(ball_posx) + `BALL_CENTER - `PL_CENTER_X - ox;
		py = int'(ball_posy) + `BALL_CENTER - `PL_CENTER_Y + oy;
		drive_player(who, px, py);
		park_players(); // one tick of overlap
		@(negedge clk100Hz);
	endtask

	task automatic wait_for_leave(input int x);
		int n;
		n = 0;
		while ((ball_posx == x) && (ball_posy == `SERVE_Y) && (n < 10)) begin
			@(negedge clk100Hz);
			n++;
		end
		assert ((ball_posx != x) || (ball_posy != `SERVE_Y)) else begin
			$display("Timeout at %0t ns: the ball never left the serve point", $time);
			errors++;
		end
	endtask

	task automatic wait_for_serve(input int x);
		int n;
		n = 0;
		while (!((ball_posx == x) && (ball_posy == `SERVE_Y)) && (n < 400)) begin
			@(negedge clk100Hz);
			n++;
		end
		assert ((ball_posx == x) && (ball_posy == `SERVE_Y)) else begin
			$display("Timeout at %0t ns: the ball was not served again at x=%0d", $time, x);
			errors++;
		end
	endtask

	task automatic fly_to_ground(output int min_x);
		int n;
		n = 0;
		min_x = ball_posx;
		while (!gnd_col && (n < 3000)) begin
			@(negedge clk100Hz);
			check_flight();
			if (ball_posx < min_x) begin
				min_x = ball_posx;
			end
			n++;
		end
		assert (gnd_col) else begin
			$display("Timeout at %0t ns: the ball never reached the ground", $time);
			errors++;
		end
	endtask

	// the ball must rest where it landed for the whole wait
	task automatic check_wait_hold(output int hold_x);
		int hx;
		int hy;
		int i;
		bit moved;
		@(negedge clk100Hz);
		hx = ball_posx;
		hy = ball_posy;
		moved = 0;
		assert (hy + `BALL_SIZE >= `GND_LVL) else begin
			$display("ERROR at %0t ns: ball resting at y=%0d, above ground", $time, hy);
			errors++;
		end
		for (i = 1; (i < `WAIT_TICKS) && !moved; i++) begin
			@(negedge clk100Hz);
			assert ((ball_posx == hx) && (ball_posy == hy)) else begin
				$display("ERROR at %0t ns: ball moved to (%0d,%0d) during the wait",
					$time, ball_posx, ball_posy);
				errors++;
				moved = 1;
			end
		end
		hold_x = hx;
	endtask

	task automatic serve_hold_test();
		int start;
		start = errors;
		check_position(0, 0, "position out of reset");
		assert (!ovr_touch) else begin
			$display("ERROR at %0t ns: ovr_touch high out of reset", $time);
			errors++;
		end
		@(negedge clk100Hz);
		check_position(`SERVE_X_PL1, `SERVE_Y, "first serve");
		repeat (100) begin
			@(negedge clk100Hz);
			check_position(`SERVE_X_PL1, `SERVE_Y, "serve hold");
		end
		report_test("serve hold", start);
	endtask

	task automatic launch_and_fall();
		int start;
		int ox;
		int oy;
		int min_x;
		int land_x;
		start = errors;
		ox = lcg_range(-10, 10);
		oy = lcg_range(30, 50);
		touch_ball(1, ox, oy);
		wait_for_leave(`SERVE_X_PL1);
		repeat (60) begin
			@(negedge clk100Hz);
			check_flight();
		end
		assert (ball_posy < `SERVE_Y) else begin
			$display("ERROR at %0t ns: ball at y=%0d did not rise", $time, ball_posy);
			errors++;
		end
		assert ((ox >= 0) ? (ball_posx >= `SERVE_X_PL1) : (ball_posx <= `SERVE_X_PL1)) else begin
			$display("ERROR at %0t ns: ball x=%0d went the wrong way, offset %0d",
				$time, ball_posx, ox);
			errors++;
		end
		fly_to_ground(min_x);
		check_wait_hold(land_x);
		wait_for_serve(`SERVE_X_PL1);
		report_test("launch", start);
	endtask

	task automatic wall_bounds();
		int start;
		int min_x;
		int land_x;
		start = errors;
		touch_ball(1, -60, 50); // hard to the left wall
		wait_for_leave(`SERVE_X_PL1);
		fly_to_ground(min_x);
		assert (min_x <= `WALL_LEFT + max_step) else begin
			$display("ERROR at %0t ns: ball turned at x=%0d, not at the wall", $time, min_x);
			errors++;
		end
		check_wait_hold(land_x);
		wait_for_serve(`SERVE_X_PL1);
		report_test("bounds", start);
	endtask

	task automatic net_rebound();
		int start;
		int min_x;
		int land_x;
		start = errors;
		touch_ball(1, 50, 30); // low and fast into the net side
		wait_for_leave(`SERVE_X_PL1);
		fly_to_ground(min_x);
		check_wait_hold(land_x);
		assert (land_x + `BALL_SIZE <= `NET_X_LO) else begin
			$display("ERROR at %0t ns: ball landed at x=%0d past the net", $time, land_x);
			errors++;
		end
		wait_for_serve(`SERVE_X_PL1);
		report_test("net", start);
	endtask

	task automatic over_touch();
		int start;
		int n;
		int tx;
		int ty;
		int hx;
		int hy;
		int i;
		bit seen;
		bit moved;
		start = errors;
		seen = 0;
		n = 0;
		while (!seen && (n < 1000)) begin
			tx = int'(ball_posx) + `BALL_CENTER - `PL_CENTER_X; // centred under the ball
			ty = int'(ball_posy) + `BALL_CENTER - `PL_CENTER_Y + 40;
			drive_player(1, tx, ty);
			@(negedge clk100Hz);
			check_flight();
			seen = ovr_touch;
			n++;
		end
		assert (seen) else begin
			$display("Timeout at %0t ns: no over-touch after %0d ticks of tracking", $time, n);
			errors++;
		end
		hx = ball_posx;
		hy = ball_posy;
		park_players();
		moved = 0;
		for (i = 0; (i < `WAIT_TICKS) && !moved; i++) begin
			@(negedge clk100Hz);
			if (i == 0) begin
				assert (!ovr_touch) else begin
					$display("ERROR at %0t ns: ovr_touch longer than one tick", $time);
					errors++;
				end
			end
			assert ((ball_posx == hx) && (ball_posy == hy)) else begin
				$display("ERROR at %0t ns: ball moved to (%0d,%0d) after the over-touch",
					$time, ball_posx, ball_posy);
				errors++;
				moved = 1;
			end
		end
		wait_for_serve(`SERVE_X_PL2); // opponent serves
		report_test("over-touch", start);
	endtask

	task automatic serve_after_player2();
		int start;
		int min_x;
		int land_x;
		start = errors;
		touch_ball(2, lcg_range(-10, 10), lcg_range(30, 50));
		wait_for_leave(`SERVE_X_PL2);
		fly_to_ground(min_x);
		check_wait_hold(land_x);
		wait_for_serve(`SERVE_X_PL2);
		report_test("serve side", start);
	endtask

	initial begin
		errors = 0;
		tests = 0;
		tests_ok = 0;
		lcg_state = 68;
		clk100Hz = 1'b0;
		rst_d = 1'b1;
		pl1_posx = `POS_W'(park_pos);
		pl1_posy = `POS_W'(park_pos);
		pl2_posx = `POS_W'(park_pos);
		pl2_posy = `POS_W'(park_pos);
		repeat (8) @(posedge clk100Hz);
		rst_d <= 1'b0;
		@(negedge clk100Hz);
		serve_hold_test();
		launch_and_fall();
		wall_bounds();
		net_rebound();
		over_touch();
		serve_after_player2();
		$display("%0d of %0d tests ok, %0d failed checks", tests_ok, tests, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- volley_ball_core.f
+incdir+include
verilog/volley_pkg.sv
verilog/ball_state_fsm.sv
verilog/ball_timers.sv
verilog/collision_detect.sv
verilog/ball_kinematics.sv
verilog/touch_referee.sv
verilog/volley_ball_core.sv
testbench/volley_ball_core_tb.sv

//--- Bender.yml
package:
  name: volley_ball_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/volley_pkg.sv
      - verilog/ball_state_fsm.sv
      - verilog/ball_timers.sv
      - verilog/collision_detect.sv
      - verilog/ball_kinematics.sv
      - verilog/touch_referee.sv
      - verilog/volley_ball_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/volley_ball_core_tb.sv
